//--- hdl/mac_init_pkg.sv
// Bus widths, startup delay, register table and command struct for MAC register init
`default_nettype none

package mac_init_pkg;

  // Bus geometry
  localparam int unsigned ADDR_W = 8;
  localparam int unsigned DATA_W = 32;

  // Number of configuration writes in the table
  localparam int unsigned NUM_REGS = 4;

  // Idle cycles after reset before the first write is queued
  localparam int unsigned STARTUP_CYCLES = 16;

  // Counter widths derived from the constants above
  localparam int unsigned STARTUP_CNT_W = $clog2(STARTUP_CYCLES);
  localparam int unsigned REG_IDX_W = $clog2(NUM_REGS);

  // One register write, last marks the final table entry
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic              last;
  } reg_cmd_t;

  // MAC configuration sequence, issued in index order
  localparam reg_cmd_t REG_TABLE [NUM_REGS] = '{
    // Command config
    '{addr: 8'h02, data: 32'h0100_0093, last: 1'b0},
    // Rx FIFO almost full threshold
    '{addr: 8'h0e, data: 32'h0000_0004, last: 1'b0},
    // Tx IPG length
    '{addr: 8'h94, data: 32'h0000_0007, last: 1'b0},
    // Command config again, so the enables take effect
    '{addr: 8'h02, data: 32'h0100_0093, last: 1'b1}
  };

endpackage

`default_nettype wire

//--- hdl/reg_write_if.sv
// Register write link between blocks, with producer, buffer and consumer modports
`default_nettype none

interface reg_write_if;

  // Write side
  logic                   push;
  mac_init_pkg::reg_cmd_t cmd_in;

  // Read side
  logic                   pop;
  mac_init_pkg::reg_cmd_t cmd_out;
  logic                   not_empty;

  // One-cycle push strobe, no back-pressure
  modport producer (
    output push,
    output cmd_in
  );

  // Buffer sees both directions
  modport buffer (
    input  push,
    input  cmd_in,
    input  pop,
    output cmd_out,
    output not_empty
  );

  // Pop only while not_empty is high
  modport consumer (
    input  cmd_out,
    input  not_empty,
    output pop
  );

endinterface

`default_nettype wire

//--- hdl/mac_cfg_sequencer.sv
// Sequencer that waits the startup delay and then pushes the register table
`default_nettype none

module mac_cfg_sequencer (
  input logic           clk,
  input logic           reset,
  reg_write_if.producer wr
);

  localparam int unsigned CNT_W = mac_init_pkg::STARTUP_CNT_W;
  localparam int unsigned IDX_W = mac_init_pkg::REG_IDX_W;

  // Terminal values of the two counters
  localparam logic [CNT_W-1:0] DELAY_END = CNT_W'(mac_init_pkg::STARTUP_CYCLES - 1);
  localparam logic [IDX_W:0]   IDX_END   = (IDX_W + 1)'(mac_init_pkg::NUM_REGS);

  logic [CNT_W-1:0] delay_cnt;
  logic             delay_done;
  // One bit wider than needed so that IDX_END marks the end of the burst
  logic [IDX_W:0]   idx;

  always_ff @(posedge clk) begin
    if (reset) begin
      delay_cnt  <= '0;
      delay_done <= 1'b0;
      idx        <= '0;
    end else if (!delay_done) begin
      // Startup delay
      if (delay_cnt == DELAY_END) begin
        delay_done <= 1'b1;
      end else begin
        delay_cnt <= delay_cnt + 1'b1;
      end
    end else if (wr.push) begin
      idx <= idx + 1'b1;
    end
  end

  // One entry per cycle until the table is exhausted
  assign wr.push = delay_done && (idx != IDX_END);

  // Upper index bit is dropped since the entry is only used while push is high
  assign wr.cmd_in = mac_init_pkg::REG_TABLE[idx[IDX_W-1:0]];

  // No push until reset has been low for the full startup delay
  assert property (@(posedge clk) disable iff (reset)
    wr.push |-> $past(!reset, mac_init_pkg::STARTUP_CYCLES));

  // At most NUM_REGS consecutive pushes in one burst
  assert property (@(posedge clk) disable iff (reset)
    wr.push |-> !$past(wr.push, mac_init_pkg::NUM_REGS));

endmodule

`default_nettype wire

//--- hdl/reg_cmd_fifo.sv
// Circular command FIFO between the sequencer and the bus master
`default_nettype none

module reg_cmd_fifo #(
  parameter int unsigned DEPTH = mac_init_pkg::NUM_REGS
) (
  input logic         clk,
  input logic         reset,
  reg_write_if.buffer wr,
  reg_write_if.buffer rd
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(DEPTH);

  mac_init_pkg::reg_cmd_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == FULL_CNT);
  assign do_push = wr.push && !full;
  assign do_pop  = rd.pop && rd.not_empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wr.cmd_in;
    end
  end

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry is valid whenever the FIFO holds something
  assign rd.not_empty = (count != '0);
  assign rd.cmd_out   = mem[rd_ptr];

  // Producer has no back-pressure, so the depth must cover every push
  assert property (@(posedge clk) disable iff (reset)
    wr.push |-> !full);

  // Consumer pops only a valid head
  assert property (@(posedge clk) disable iff (reset)
    rd.pop |-> rd.not_empty);

endmodule

`default_nettype wire

//--- hdl/avalon_write_master.sv
// Bus write master that drains the command FIFO and raises done after the last write
`default_nettype none

module avalon_write_master (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              waitrequest,
  // Read path unused and readdata never sampled
  input  logic [mac_init_pkg::DATA_W-1:0]   readdata,
  reg_write_if.consumer                     cmd,
  output logic [mac_init_pkg::ADDR_W-1:0]   address,
  output logic [mac_init_pkg::DATA_W-1:0]   writedata,
  output logic                              write,
  output logic                              read,
  output logic                              done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_DONE
  } state_t;

  state_t state;
  logic   last_q;
  logic   accept;

  // Write completes when the slave drops waitrequest
  assign accept = write && !waitrequest;

  // Fetch only from idle, one command per write
  assign cmd.pop = (state == ST_IDLE) && cmd.not_empty;

  assign read = 1'b0;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      address   <= '0;
      writedata <= '0;
      write     <= 1'b0;
      last_q    <= 1'b0;
      done      <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd.pop) begin
            address   <= cmd.cmd_out.addr;
            writedata <= cmd.cmd_out.data;
            last_q    <= cmd.cmd_out.last;
            write     <= 1'b1;
            state     <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          // Address and data held until accepted
          if (accept) begin
            write <= 1'b0;
            if (last_q) begin
              done  <= 1'b1;
              state <= ST_DONE;
            end else begin
              state <= ST_IDLE;
            end
          end
        end
        ST_DONE: begin
          // Terminal until reset
          state <= ST_DONE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Payload frozen while the slave stalls
  assert property (@(posedge clk) disable iff (reset)
    (write && waitrequest) |=> ($stable(address) && $stable(writedata)));

  // No bus activity outside the write state
  assert property (@(posedge clk) disable iff (reset)
    (state != ST_WRITE) |-> !write);

endmodule

`default_nettype wire

//--- hdl/mac_reg_init.sv
// Top level of the MAC register init, sequencer to FIFO to bus master
`default_nettype none

module mac_reg_init (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            waitrequest,
  input  logic [mac_init_pkg::DATA_W-1:0] readdata,
  output logic [mac_init_pkg::ADDR_W-1:0] address,
  output logic [mac_init_pkg::DATA_W-1:0] writedata,
  output logic                            write,
  output logic                            read,
  output logic                            done
);

  // Internal command links
  reg_write_if seq_to_fifo ();
  reg_write_if fifo_to_master ();

  mac_cfg_sequencer u_seq (
    .clk   (clk),
    .reset (reset),
    .wr    (seq_to_fifo.producer)
  );

  // Depth equals the table length, so pushes never overflow
  reg_cmd_fifo #(
    .DEPTH (mac_init_pkg::NUM_REGS)
  ) u_fifo (
    .clk   (clk),
    .reset (reset),
    .wr    (seq_to_fifo.buffer),
    .rd    (fifo_to_master.buffer)
  );

  avalon_write_master u_master (
    .clk         (clk),
    .reset       (reset),
    .waitrequest (waitrequest),
    .readdata    (readdata),
    .cmd         (fifo_to_master.consumer),
    .address     (address),
    .writedata   (writedata),
    .write       (write),
    .read        (read),
    .done        (done)
  );

endmodule

`default_nettype wire

//--- test/mac_bus_monitor.sv
// Bus checker comparing accepted writes with the register table, with per-test and total counts
`default_nettype none

module mac_bus_monitor (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            waitrequest,
  input  logic [mac_init_pkg::ADDR_W-1:0] address,
  input  logic [mac_init_pkg::DATA_W-1:0] writedata,
  input  logic                            write,
  input  logic                            read,
  input  logic                            done,
  input  logic                            end_test,
  input  int                              test_num,
  output int                              tests_run,
  output int                              tests_failed,
  output int                              error_total
);

  localparam int unsigned DW = mac_init_pkg::DATA_W;
  localparam int unsigned IDX_W = mac_init_pkg::REG_IDX_W;
  localparam logic [IDX_W:0] IDX_END = (IDX_W + 1)'(mac_init_pkg::NUM_REGS);

  // Next expected table entry, counts accepted writes since reset
  logic [IDX_W:0]                  idx;
  logic                            reset_q;
  logic                            stall_q;
  logic                            done_q;
  logic [mac_init_pkg::ADDR_W-1:0] addr_q;
  logic [DW-1:0]                   data_q;
  mac_init_pkg::reg_cmd_t          exp_cmd;

  // Cycles with reset low since the last reset
  int quiet_cnt = 0;
  int test_errors = 0;
  int run_cnt = 0;
  int failed_cnt = 0;
  int total_cnt = 0;

  assign tests_run    = run_cnt;
  assign tests_failed = failed_cnt;
  assign error_total  = total_cnt;

  task automatic mismatch(input string sig, input logic [DW-1:0] exp_v,
                          input logic [DW-1:0] act_v);
    $display("[ERROR] time %0t: %s expected %h, got %h", $time, sig, exp_v, act_v);
    test_errors++;
  endtask

  task automatic failure(input string what);
    $display("Check failed at time %0t: %s", $time, what);
    test_errors++;
  endtask

  always @(posedge clk) begin
    if (read === 1'b1) failure("read strobe went high");

    // Outputs held at zero during reset and in the first cycle after it
    if (reset_q === 1'b1) begin
      if (address != '0) mismatch("address", '0, DW'(address));
      if (writedata != '0) mismatch("writedata", '0, writedata);
      if (write) mismatch("write", '0, DW'(write));
      if (done) mismatch("done", '0, DW'(done));
    end

    if (!reset) begin
      if (write && quiet_cnt < mac_init_pkg::STARTUP_CYCLES) begin
        failure("write asserted before the startup delay ended");
      end
      // Payload frozen through a stall
      if (stall_q) begin
        if (address != addr_q) mismatch("address", DW'(addr_q), DW'(address));
        if (writedata != data_q) mismatch("writedata", data_q, writedata);
        if (!write) failure("write dropped while waitrequest was high");
      end
      if (write && !waitrequest) begin
        if (done || idx == IDX_END) begin
          failure("write accepted after the sequence had completed");
        end else begin
          exp_cmd = mac_init_pkg::REG_TABLE[idx[IDX_W-1:0]];
          if (address != exp_cmd.addr) mismatch("address", DW'(exp_cmd.addr), DW'(address));
          if (writedata != exp_cmd.data) mismatch("writedata", exp_cmd.data, writedata);
        end
      end
      if (done && idx != IDX_END) failure("done rose before the fourth write was accepted");
      if (done_q && !done) failure("done fell without a reset");
    end

    if (end_test) begin
      if (idx != IDX_END) begin
        failure($sformatf("expected %0d writes, saw %0d", mac_init_pkg::NUM_REGS, idx));
      end
      if (!done) failure("done is low at the end of the test");
      $display("test %0d: %0d writes, %0d errors, %s", test_num, idx, test_errors,
               (test_errors == 0) ? "PASS" : "FAIL");
      run_cnt++;
      if (test_errors != 0) failed_cnt++;
      total_cnt += test_errors;
      test_errors = 0;
    end

    reset_q <= reset;
    stall_q <= !reset && write && waitrequest;
    addr_q  <= address;
    data_q  <= writedata;
    done_q  <= done;
    if (reset) begin
      idx       <= '0;
      quiet_cnt <= 0;
    end else begin
      quiet_cnt <= quiet_cnt + 1;
      if (write && !waitrequest && idx != IDX_END) begin
        idx <= idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_mac_reg_init.sv
// Testbench top with clock, reset, stall table, waitrequest driver, DUT and bus checker
`default_nettype none

module tb_mac_reg_init;

  typedef enum logic [1:0] {
    STALL_NONE,
    STALL_FIXED,
    STALL_RANDOM
  } stall_mode_t;

  localparam int NUM_TESTS = 5;
  localparam int DONE_TIMEOUT = 400;
  localparam int QUIET_CYCLES = 12;

  logic                            clk = 1'b0;
  logic                            reset = 1'b1;
  logic                            waitrequest = 1'b0;
  logic [mac_init_pkg::DATA_W-1:0] readdata = '0;
  logic [mac_init_pkg::ADDR_W-1:0] address;
  logic [mac_init_pkg::DATA_W-1:0] writedata;
  logic                            write;
  logic                            read;
  logic                            done;

  logic end_test = 1'b0;
  int   test_num = 0;
  int   tests_run;
  int   tests_failed;
  int   error_total;

  // Stimulus table
  string       row_name [NUM_TESTS];
  stall_mode_t row_mode [NUM_TESTS];
  int          row_stall [NUM_TESTS];
  logic        row_mid_reset [NUM_TESTS];

  // Waitrequest driver state
  stall_mode_t cur_mode = STALL_NONE;
  int          cur_stall = 0;
  int          stall_left = 0;
  int          drawn_stall;
  logic [31:0] lfsr = 32'hdecd57bb;

  logic timed_out;
  logic ok;

  always #2 clk = ~clk;

  mac_reg_init DUT (
    .clk         (clk),
    .reset       (reset),
    .waitrequest (waitrequest),
    .readdata    (readdata),
    .address     (address),
    .writedata   (writedata),
    .write       (write),
    .read        (read),
    .done        (done)
  );

  mac_bus_monitor u_checker (
    .clk          (clk),
    .reset        (reset),
    .waitrequest  (waitrequest),
    .address      (address),
    .writedata    (writedata),
    .write        (write),
    .read         (read),
    .done         (done),
    .end_test     (end_test),
    .test_num     (test_num),
    .tests_run    (tests_run),
    .tests_failed (tests_failed),
    .error_total  (error_total)
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Stall length for the next write, up to 7 cycles when random
  task automatic pick_stall(output int n);
    logic [2:0] bits;
    int         b;
    bits = '0;
    case (cur_mode)
      STALL_FIXED: n = cur_stall;
      STALL_RANDOM: begin
        for (b = 0; b < 3; b++) begin
          lfsr = lfsr_next(lfsr);
          bits = {bits[1:0], lfsr[0]};
        end
        n = int'(bits);
      end
      default: n = 0;
    endcase
  endtask

  // Waitrequest high for the drawn number of cycles after write rises
  always @(posedge clk) begin
    if (reset || (write && !waitrequest)) begin
      pick_stall(drawn_stall);
      stall_left  <= drawn_stall;
      waitrequest <= (drawn_stall != 0);
    end else if (write && waitrequest) begin
      stall_left  <= stall_left - 1;
      waitrequest <= (stall_left > 1);
    end
  end

  task automatic set_row(input int idx, input string name, input stall_mode_t mode,
                         input int stall, input logic mid_reset);
    row_name[idx]      = name;
    row_mode[idx]      = mode;
    row_stall[idx]     = stall;
    row_mid_reset[idx] = mid_reset;
  endtask

  task automatic apply_reset();
    int c;
    @(posedge clk);
    reset <= 1'b1;
    for (c = 0; c < 4; c++) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic wait_for_accepts(input int count, input int limit, output logic got);
    int n;
    int seen;
    got  = 1'b0;
    seen = 0;
    for (n = 0; n < limit && !got; n++) begin
      @(posedge clk);
      if (write && !waitrequest) seen++;
      if (seen == count) got = 1'b1;
    end
  endtask

  task automatic wait_for_done(input int limit, output logic got);
    int n;
    got = 1'b0;
    for (n = 0; n < limit && !got; n++) begin
      @(posedge clk);
      if (done) got = 1'b1;
    end
  endtask

  initial begin
    int i;
    set_row(0, "no_stall", STALL_NONE, 0, 1'b0);
    set_row(1, "fixed_stall_3", STALL_FIXED, 3, 1'b0);
    set_row(2, "random_stall", STALL_RANDOM, 0, 1'b0);
    set_row(3, "random_mid_reset", STALL_RANDOM, 0, 1'b1);
    set_row(4, "fixed_stall_7_mid_reset", STALL_FIXED, 7, 1'b1);
    timed_out = 1'b0;

    for (i = 0; i < NUM_TESTS && !timed_out; i++) begin
      cur_mode  <= row_mode[i];
      cur_stall <= row_stall[i];
      test_num  <= i;
      apply_reset();
      if (row_mid_reset[i]) begin
        // Interrupt the sequence after two writes
        wait_for_accepts(2, DONE_TIMEOUT, ok);
        if (!ok) begin
          $display("Timeout: two writes were not accepted in test %s", row_name[i]);
          timed_out = 1'b1;
        end else begin
          apply_reset();
        end
      end
      if (!timed_out) begin
        wait_for_done(DONE_TIMEOUT, ok);
        if (!ok) begin
          $display("Timeout: done did not rise within %0d cycles in test %s",
                   DONE_TIMEOUT, row_name[i]);
          timed_out = 1'b1;
        end
      end
      if (!timed_out) begin
        // Watch for stray writes after done
        repeat (QUIET_CYCLES) @(posedge clk);
        end_test <= 1'b1;
        @(posedge clk);
        end_test <= 1'b0;
        @(posedge clk);
      end
    end

    @(posedge clk);
    $display("Tests run %0d, failing %0d, errors %0d", tests_run, tests_failed, error_total);
    if (timed_out || tests_failed != 0 || tests_run != NUM_TESTS) begin
      $display("tests failed");
    end else begin
      $display("all tests passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
hdl/mac_init_pkg.sv
hdl/reg_write_if.sv
hdl/mac_cfg_sequencer.sv
hdl/reg_cmd_fifo.sv
hdl/avalon_write_master.sv
hdl/mac_reg_init.sv
test/mac_bus_monitor.sv
test/tb_mac_reg_init.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the MAC register init testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f compile.f --top-module tb_mac_reg_init \
  -o tb_mac_reg_init > build.log 2>&1 \
  && ./obj_dir/tb_mac_reg_init > sim.log 2>&1 \
  || { echo "Build or simulation aborted"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
  || { echo "Simulation PASSED"; exit 0; }
